//--- src.f
src/gtePkg.sv
src/gteSequencer.sv
src/gteMicroRom.sv
src/gteRegFile.sv
src/gteComputePath.sv
src/gteEngine.sv
test/gteEngineTb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module gteEngineTb -f src.f -o simv
./obj_dir/simv | tee sim.log

if grep -qx "all tests passed" sim.log; then
	exit 0
fi
exit 1

//--- test/gteEngineTb.sv
`timescale 1ns/100ps
`default_nettype none

module gteEngineTb;
	import gtePkg::*;

	localparam int ClkPeriod     = 20;
	localparam int ResetCycles   = 5;
	localparam int TestCount     = 5;
	localparam int CyclesPerTest = 200;
	localparam int RegCount      = 26;

	logic                  clk;
	logic                  rst;
	eRegId                 regId;
	logic                  cpuWrite;
	logic [31:0]           dataIn;
	wire  [31:0]           dataOut;
	logic [InstrWidth-1:0] instruction;
	logic                  run;
	wire                   executing;

	logic [31:0] expData;       // Value the selected register should read
	logic        checkStrobe;
	int          shadow [RegCount];  // Reference copy of every register
	int          errCount;
	int          checkCount;
	int          testErrStart;
	int          testNum;

	gteEngine DUT (
		.i_clk         (clk),
		.i_rst         (rst),
		.i_regId       (regId),
		.i_writeReg    (cpuWrite),
		.i_dataIn      (dataIn),
		.o_dataOut     (dataOut),
		.i_instruction (instruction),
		.i_run         (run),
		.o_executing   (executing)
	);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	// Read port compared against the reference whenever a check is posted
	readBack: assert property (@(posedge clk) checkStrobe |-> dataOut == expData)
	else begin
		errCount++;
		$display("ERR t=%0t: %s read %h, expected %h", $time, regId.name(), dataOut, expData);
	end

	// ------------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------------

	function automatic int randRange(input int mag);
		return int'($urandom % (2 * mag)) - mag;  // -mag .. mag-1
	endfunction

	function automatic logic [InstrWidth-1:0] encodeInstr(input logic [5:0] opc, input bit sf,
			input bit lm, input logic [1:0] cv, input logic [1:0] vec);
		logic [InstrWidth-1:0] instr;
		instr             = '0;
		instr[5:0]        = opc;
		instr[SfBit]      = sf;
		instr[LmBit]      = lm;
		instr[CvLsb +: 2] = cv;
		instr[VecLsb +: 2] = vec;
		return instr;
	endfunction

	function automatic int shadowAt(input eRegId base, input int offset);
		return shadow[int'(base) + offset];
	endfunction

	// CPU write as seen on a later read
	function automatic void storeShadow(input eRegId id, input logic [31:0] val);
		if (id inside {MAC1, MAC2, MAC3}) begin
			shadow[int'(id)] = val;
		end else if (id == FLAG) begin
			shadow[int'(id)] = {29'd0, val[2:0]};
		end else begin
			shadow[int'(id)] = {{16{val[15]}}, val[15:0]};  // Low half, sign-extended
		end
	endfunction

	// One instruction applied to the reference registers
	function automatic void modelOp(input logic [InstrWidth-1:0] instr);
		logic [5:0] opc;
		logic [1:0] vec;
		int         vecVal [3];
		longint     sum [3];
		longint     shifted;
		int         mac;
		int         lowBound;
		opc = instr[5:0];
		vec = instr[VecLsb +: 2];
		shadow[int'(FLAG)] = 0;  // Every accepted instruction clears FLAG
		if (opc != MVMVA && opc != SQR && opc != GPF) begin
			return;
		end
		for (int j = 0; j < 3; j++) begin
			vecVal[j] = (vec == 2'd0) ? shadowAt(VX0, j) :
				(vec == 2'd1) ? shadowAt(VX1, j) : shadowAt(IR1, j);
		end
		// All lanes from the state before the instruction
		for (int i = 0; i < 3; i++) begin
			sum[i] = 0;
			if (opc == MVMVA) begin
				for (int j = 0; j < 3; j++) begin
					sum[i] += longint'(shadowAt(R11, 3 * i + j)) * vecVal[j];
				end
				if (instr[CvLsb +: 2] == 2'd0) begin
					sum[i] += longint'(shadowAt(TRX, i)) <<< FracBits;
				end
			end else if (opc == SQR) begin
				sum[i] = longint'(shadowAt(IR1, i)) * shadowAt(IR1, i);
			end else begin
				sum[i] = longint'(shadowAt(IR0, 0)) * shadowAt(IR1, i);
			end
		end
		lowBound = instr[LmBit] ? 0 : -32768;
		for (int i = 0; i < 3; i++) begin
			shifted = instr[SfBit] ? (sum[i] >>> FracBits) : sum[i];
			mac     = shifted[31:0];  // MAC keeps 32 bits
			shadow[int'(MAC1) + i] = mac;
			if (mac > 32767 || mac < lowBound) begin
				shadow[int'(IR1) + i] = (mac > 32767) ? 32767 : lowBound;
				shadow[int'(FLAG)] |= (1 << i);
			end else begin
				shadow[int'(IR1) + i] = mac;
			end
		end
	endfunction

	// ------------------------------------------------------------------------
	// Bus tasks, each starts and ends just after a falling edge
	// ------------------------------------------------------------------------

	task automatic writeReg(input eRegId id, input logic [31:0] val);
		regId    = id;
		dataIn   = val;
		cpuWrite = 1'b1;
		storeShadow(id, val);
		@(negedge clk);
		cpuWrite = 1'b0;
	endtask

	task automatic checkReg(input eRegId id);
		regId       = id;
		expData     = shadow[int'(id)];
		checkStrobe = 1'b1;
		checkCount++;
		@(negedge clk);
		checkStrobe = 1'b0;
	endtask

	task automatic checkAllRegs();
		for (int k = 0; k < RegCount; k++) begin
			checkReg(eRegId'(k));
		end
	endtask

	// Strobe, then count busy cycles until the level drops
	task automatic runOp(input logic [InstrWidth-1:0] instr, input int expBusy,
			input bit injectRun, input bit settle);
		int busy;
		busy = 0;
		modelOp(instr);
		instruction = instr;
		run         = 1'b1;
		@(negedge clk);
		run = 1'b0;
		while (executing) begin
			busy++;
			if (injectRun && busy == 1) begin
				instruction = encodeInstr(SQR, 1'b1, 1'b1, 2'd0, 2'd0);  // Must be ignored
				run         = 1'b1;
			end else begin
				run = 1'b0;
			end
			@(negedge clk);
		end
		run = 1'b0;
		checkCount++;
		assert (busy == expBusy) else begin
			errCount++;
			$display("ERR t=%0t: busy for %0d cycles, expected %0d", $time, busy, expBusy);
		end
		if (settle) begin
			@(negedge clk);  // Last write-back lands one cycle after the drop
		end
	endtask

	task automatic beginTest();
		testNum++;
		testErrStart = errCount;
	endtask

	task automatic endTest(input string name);
		if (errCount == testErrStart) begin
			$display("test %0d %s: ok", testNum, name);
		end else begin
			$display("test %0d %s: FAIL with %0d errors", testNum, name, errCount - testErrStart);
		end
	endtask

	// ------------------------------------------------------------------------
	// Watchdog
	// ------------------------------------------------------------------------

	initial begin
		#(TestCount * CyclesPerTest * ClkPeriod);
		$display("Watchdog: run did not finish within %0d cycles", TestCount * CyclesPerTest);
		$display("tests failed");
		$finish;
	end

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------

	initial begin
		void'($urandom(32'h40e0));
		rst          = 1'b1;
		regId        = VX0;
		cpuWrite     = 1'b0;
		dataIn       = '0;
		instruction  = '0;
		run          = 1'b0;
		expData      = '0;
		checkStrobe  = 1'b0;
		errCount     = 0;
		checkCount   = 0;
		testErrStart = 0;
		testNum      = 0;
		for (int k = 0; k < RegCount; k++) begin
			shadow[k] = 0;
		end
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Reset state, then CPU write and read back
		beginTest();
		checkCount++;
		assert (!executing) else begin
			errCount++;
			$display("ERR t=%0t: executing high after reset", $time);
		end
		checkAllRegs();
		for (int k = 0; k < RegCount; k++) begin
			writeReg(eRegId'(k), $urandom());
		end
		writeReg(VX0, 32'h0001_8001);  // Negative low half
		checkAllRegs();
		endTest("reset and register access");

		// MVMVA, translation on and off, both vectors
		beginTest();
		for (int k = int'(R11); k <= int'(TRZ); k++) begin
			writeReg(eRegId'(k), randRange(32768));
		end
		for (int k = int'(VX0); k <= int'(VZ1); k++) begin
			writeReg(eRegId'(k), randRange(2048));  // Keeps some lanes in range
		end
		runOp(encodeInstr(MVMVA, 1'b0, 1'b0, 2'd0, 2'd0), 3, 1'b0, 1'b1);
		checkAllRegs();
		runOp(encodeInstr(MVMVA, 1'b1, 1'b0, 2'd0, 2'd0), 3, 1'b0, 1'b1);
		checkAllRegs();
		runOp(encodeInstr(MVMVA, 1'b1, 1'b1, 2'd3, 2'd1), 3, 1'b0, 1'b1);
		checkAllRegs();
		endTest("mvmva");

		// SQR saturation, FLAG, then FLAG cleared by a NOP
		beginTest();
		writeReg(IR1, 20000);
		writeReg(IR2, -30000);
		writeReg(IR3, 100);
		runOp(encodeInstr(SQR, 1'b0, 1'b0, 2'd0, 2'd0), 3, 1'b0, 1'b1);
		checkAllRegs();
		runOp(encodeInstr(SQR, 1'b1, 1'b1, 2'd0, 2'd0), 3, 1'b0, 1'b1);
		checkAllRegs();
		runOp(encodeInstr(NOP, 1'b0, 1'b0, 2'd0, 2'd0), 1, 1'b0, 1'b1);
		checkReg(FLAG);
		endTest("sqr");

		// GPF random, then negative products at both clamp settings
		beginTest();
		for (int k = int'(IR0); k <= int'(IR3); k++) begin
			writeReg(eRegId'(k), randRange(32768));
		end
		runOp(encodeInstr(GPF, 1'b0, 1'b0, 2'd0, 2'd0), 3, 1'b0, 1'b1);
		checkAllRegs();
		writeReg(IR0, -30000);
		writeReg(IR1, 20000);
		writeReg(IR2, -20000);
		writeReg(IR3, 3);
		runOp(encodeInstr(GPF, 1'b0, 1'b0, 2'd0, 2'd0), 3, 1'b0, 1'b1);
		checkAllRegs();
		writeReg(IR1, 20000);
		runOp(encodeInstr(GPF, 1'b1, 1'b1, 2'd0, 2'd0), 3, 1'b0, 1'b1);
		checkAllRegs();
		endTest("gpf");

		// Busy time, ignored strobe, back-to-back issue
		beginTest();
		runOp(encodeInstr(NOP, 1'b0, 1'b0, 2'd0, 2'd0), 1, 1'b0, 1'b1);
		runOp(encodeInstr(6'h01, 1'b1, 1'b1, 2'd0, 2'd0), 1, 1'b0, 1'b1);  // Unknown code
		checkAllRegs();
		for (int k = int'(IR0); k <= int'(IR3); k++) begin
			writeReg(eRegId'(k), randRange(32768));
		end
		runOp(encodeInstr(GPF, 1'b1, 1'b0, 2'd0, 2'd0), 3, 1'b1, 1'b1);
		checkAllRegs();
		runOp(encodeInstr(SQR, 1'b1, 1'b0, 2'd0, 2'd0), 3, 1'b0, 1'b0);
		runOp(encodeInstr(GPF, 1'b1, 1'b0, 2'd0, 2'd0), 3, 1'b0, 1'b1);  // Uses SQR results
		checkAllRegs();
		endTest("timing");

		$display("%0d tests, %0d checks, %0d errors", testNum, checkCount, errCount);
		if (errCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src/gteEngine.sv
`timescale 1ns/100ps
`default_nettype none

module gteEngine (
	input  wire                          i_clk,
	input  wire                          i_rst,
	input  wire gtePkg::eRegId           i_regId,
	input  wire                          i_writeReg,
	input  wire [31:0]                   i_dataIn,
	output wire [31:0]                   o_dataOut,
	input  wire [gtePkg::InstrWidth-1:0] i_instruction,
	input  wire                          i_run,       // One-cycle strobe
	output wire                          o_executing
);
	import gtePkg::*;

	logic [PcWidth-1:0] pc;
	logic [PcWidth-1:0] startAdr;
	sMicroOp            microOp;    // ROM word at pc
	sMicroOp            step;       // Same word, gated by busy
	sInstrCtrl          instrCtrl;
	sRegView            regView;
	sWriteBack          wb;
	logic               load;       // Clears FLAG too

	gteSequencer u_sequencer (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_run         (i_run),
		.i_instruction (i_instruction),
		.i_startAdr    (startAdr),
		.i_microOp     (microOp),
		.o_pc          (pc),
		.o_step        (step),
		.o_instrCtrl   (instrCtrl),
		.o_load        (load),
		.o_executing   (o_executing)
	);

	gteMicroRom u_microRom (
		.i_opcode   (eOpcode'(i_instruction[5:0])),
		.i_pc       (pc),
		.o_startAdr (startAdr),
		.o_microOp  (microOp)
	);

	gteComputePath u_computePath (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_step      (step),
		.i_instrCtrl (instrCtrl),
		.i_regs      (regView),
		.o_wb        (wb)
	);

	gteRegFile u_regFile (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_regId    (i_regId),
		.i_writeReg (i_writeReg),
		.i_dataIn   (i_dataIn),
		.i_wb       (wb),
		.i_load     (load),
		.o_dataOut  (o_dataOut),
		.o_regs     (regView)
	);

endmodule

`default_nettype wire

//--- src/gteComputePath.sv
`timescale 1ns/100ps
`default_nettype none

module gteComputePath (
	input  wire                    i_clk,
	input  wire                    i_rst,
	input  wire gtePkg::sMicroOp   i_step,
	input  wire gtePkg::sInstrCtrl i_instrCtrl,
	input  wire gtePkg::sRegView   i_regs,
	output gtePkg::sWriteBack      o_wb
);
	import gtePkg::*;

	logic [1:0]                 laneIdx;   // Zero based row select
	tS16 [2:0]                  liveVec;
	tS16 [2:0]                  heldVec;
	tS16 [2:0]                  opVec;
	tS16                        opA [3];
	tS16                        opB [3];
	logic signed [AccWidth-1:0] prod [3];
	logic signed [AccWidth-1:0] trTerm;
	logic signed [AccWidth-1:0] sum;
	logic signed [AccWidth-1:0] shifted;
	logic signed [31:0]         mac;
	logic signed [31:0]         lowBound;
	tS16                        irSat;
	logic                       sat;
	sWriteBack                  wbQ;

	// ------------------------------------------------------------------------
	// Operand selection
	// ------------------------------------------------------------------------

	assign laneIdx = (i_step.lane == 2'd0) ? 2'd0 : i_step.lane - 2'd1;

	always_comb begin
		case (i_instrCtrl.vec)
			2'd0:    liveVec = i_regs.v0;
			2'd1:    liveVec = i_regs.v1;
			default: liveVec = i_regs.ir[3:1];  // IR1..IR3 as a vector
		endcase
	end

	// IR vector is rewritten while MVMVA runs, so lanes 2 and 3 use the
	// copy taken on lane 1
	always_ff @(posedge i_clk) begin
		if (i_step.writeEn && i_step.lane == 2'd1) begin
			heldVec <= liveVec;
		end
	end

	assign opVec = (i_step.lane == 2'd1) ? liveVec : heldVec;

	always_comb begin
		for (int j = 0; j < 3; j++) begin
			opA[j] = '0;
			opB[j] = '0;
		end
		case (i_step.termSel)
			MATRIX_ROW: begin
				for (int j = 0; j < 3; j++) begin
					opA[j] = i_regs.rt[laneIdx][j];
					opB[j] = opVec[j];
				end
			end
			SQUARE: begin
				opA[0] = i_regs.ir[i_step.lane];
				opB[0] = i_regs.ir[i_step.lane];
			end
			IR0_SCALE: begin
				opA[0] = i_regs.ir[0];
				opB[0] = i_regs.ir[i_step.lane];
			end
			default: ;  // Zero operands
		endcase
	end

	// ------------------------------------------------------------------------
	// Sum, shift, saturate
	// ------------------------------------------------------------------------

	always_comb begin
		for (int j = 0; j < 3; j++) begin
			prod[j] = opA[j] * opB[j];  // Signed, extended to AccWidth
		end
		trTerm = $signed(i_regs.tr[laneIdx]);
		trTerm = trTerm <<< FracBits;  // TR sits at the product's scale
		if (!(i_step.addTr && i_instrCtrl.cv == 2'd0)) begin
			trTerm = '0;
		end
		sum     = prod[0] + prod[1] + prod[2] + trTerm;
		shifted = i_instrCtrl.sf ? (sum >>> FracBits) : sum;
		mac     = shifted[31:0];  // MAC keeps the low 32 bits
	end

	always_comb begin
		lowBound = i_instrCtrl.lm ? 32'sd0 : IrMin;
		if (mac > IrMax) begin
			irSat = tS16'(IrMax);
			sat   = 1'b1;
		end else if (mac < lowBound) begin
			irSat = tS16'(lowBound);
			sat   = 1'b1;
		end else begin
			irSat = mac[15:0];
			sat   = 1'b0;
		end
	end

	// Single pipeline stage towards the register file
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wbQ.en <= 1'b0;
		end else begin
			wbQ.en   <= i_step.writeEn;
			wbQ.lane <= i_step.lane;
			wbQ.mac  <= mac;
			wbQ.ir   <= irSat;
			wbQ.sat  <= sat;
		end
	end

	assign o_wb = wbQ;

	// Every engine write-back targets one of lanes 1..3
	wbLaneValid: assert property (
		@(posedge i_clk) disable iff (i_rst)
		o_wb.en |-> o_wb.lane != 2'd0
	) else $error("Write-back with lane 0");

endmodule

`default_nettype wire

//--- src/gteRegFile.sv
`timescale 1ns/100ps
`default_nettype none

module gteRegFile (
	input  wire                    i_clk,
	input  wire                    i_rst,
	input  wire gtePkg::eRegId     i_regId,
	input  wire                    i_writeReg,
	input  wire [31:0]             i_dataIn,
	input  wire gtePkg::sWriteBack i_wb,
	input  wire                    i_load,
	output logic [31:0]            o_dataOut,
	output gtePkg::sRegView        o_regs
);
	import gtePkg::*;

	sRegView            regQ;
	logic signed [31:0] macQ [1:3];
	logic [3:1]         flagQ;     // flagQ[i] is FLAG bit i-1
	tS16                cpuHalf;

	function automatic logic [31:0] sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	assign cpuHalf = i_dataIn[15:0];  // 16-bit registers keep the low half

	// ------------------------------------------------------------------------
	// Write side, CPU first then engine so the engine wins a collision
	// ------------------------------------------------------------------------

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			regQ  <= '0;
			flagQ <= '0;
			for (int i = 1; i <= 3; i++) begin
				macQ[i] <= '0;
			end
		end else begin
			if (i_writeReg) begin
				case (i_regId)
					VX0:  regQ.v0[0] <= cpuHalf;
					VY0:  regQ.v0[1] <= cpuHalf;
					VZ0:  regQ.v0[2] <= cpuHalf;
					VX1:  regQ.v1[0] <= cpuHalf;
					VY1:  regQ.v1[1] <= cpuHalf;
					VZ1:  regQ.v1[2] <= cpuHalf;
					IR0:  regQ.ir[0] <= cpuHalf;
					IR1:  regQ.ir[1] <= cpuHalf;
					IR2:  regQ.ir[2] <= cpuHalf;
					IR3:  regQ.ir[3] <= cpuHalf;
					MAC1: macQ[1] <= i_dataIn;   // Full width
					MAC2: macQ[2] <= i_dataIn;
					MAC3: macQ[3] <= i_dataIn;
					FLAG: flagQ <= i_dataIn[2:0];
					R11:  regQ.rt[0][0] <= cpuHalf;
					R12:  regQ.rt[0][1] <= cpuHalf;
					R13:  regQ.rt[0][2] <= cpuHalf;
					R21:  regQ.rt[1][0] <= cpuHalf;
					R22:  regQ.rt[1][1] <= cpuHalf;
					R23:  regQ.rt[1][2] <= cpuHalf;
					R31:  regQ.rt[2][0] <= cpuHalf;
					R32:  regQ.rt[2][1] <= cpuHalf;
					R33:  regQ.rt[2][2] <= cpuHalf;
					TRX:  regQ.tr[0] <= cpuHalf;
					TRY:  regQ.tr[1] <= cpuHalf;
					TRZ:  regQ.tr[2] <= cpuHalf;
					default: ;
				endcase
			end
			if (i_wb.en) begin
				macQ[i_wb.lane]    <= i_wb.mac;
				regQ.ir[i_wb.lane] <= i_wb.ir;
				if (i_wb.sat) begin
					flagQ[i_wb.lane] <= 1'b1;  // Sticky until next load
				end
			end
			if (i_load) begin
				flagQ <= '0;  // New instruction starts with a clean FLAG
			end
		end
	end

	// ------------------------------------------------------------------------
	// Read side, combinational
	// ------------------------------------------------------------------------

	always_comb begin
		case (i_regId)
			VX0:     o_dataOut = sext16(regQ.v0[0]);
			VY0:     o_dataOut = sext16(regQ.v0[1]);
			VZ0:     o_dataOut = sext16(regQ.v0[2]);
			VX1:     o_dataOut = sext16(regQ.v1[0]);
			VY1:     o_dataOut = sext16(regQ.v1[1]);
			VZ1:     o_dataOut = sext16(regQ.v1[2]);
			IR0:     o_dataOut = sext16(regQ.ir[0]);
			IR1:     o_dataOut = sext16(regQ.ir[1]);
			IR2:     o_dataOut = sext16(regQ.ir[2]);
			IR3:     o_dataOut = sext16(regQ.ir[3]);
			MAC1:    o_dataOut = macQ[1];
			MAC2:    o_dataOut = macQ[2];
			MAC3:    o_dataOut = macQ[3];
			FLAG:    o_dataOut = {29'd0, flagQ};
			R11:     o_dataOut = sext16(regQ.rt[0][0]);
			R12:     o_dataOut = sext16(regQ.rt[0][1]);
			R13:     o_dataOut = sext16(regQ.rt[0][2]);
			R21:     o_dataOut = sext16(regQ.rt[1][0]);
			R22:     o_dataOut = sext16(regQ.rt[1][1]);
			R23:     o_dataOut = sext16(regQ.rt[1][2]);
			R31:     o_dataOut = sext16(regQ.rt[2][0]);
			R32:     o_dataOut = sext16(regQ.rt[2][1]);
			R33:     o_dataOut = sext16(regQ.rt[2][2]);
			TRX:     o_dataOut = sext16(regQ.tr[0]);
			TRY:     o_dataOut = sext16(regQ.tr[1]);
			TRZ:     o_dataOut = sext16(regQ.tr[2]);
			default: o_dataOut = '0;
		endcase
	end

	assign o_regs = regQ;

endmodule

`default_nettype wire

//--- src/gteMicroRom.sv
`timescale 1ns/100ps
`default_nettype none

module gteMicroRom (
	input  wire gtePkg::eOpcode         i_opcode,
	input  wire [gtePkg::PcWidth-1:0]   i_pc,
	output logic [gtePkg::PcWidth-1:0]  o_startAdr,
	output gtePkg::sMicroOp             o_microOp
);
	import gtePkg::*;

	// Builds one ROM word
	function automatic sMicroOp uop(
		input eTermSel    termSel,
		input logic [1:0] lane,
		input logic       addTr,
		input logic       writeEn,
		input logic       last
	);
		sMicroOp op;
		op.termSel = termSel;
		op.lane    = lane;
		op.addTr   = addTr;
		op.writeEn = writeEn;
		op.last    = last;
		return op;
	endfunction

	// ------------------------------------------------------------------------
	// Start address per opcode
	// ------------------------------------------------------------------------

	always_comb begin
		case (i_opcode)
			MVMVA:   o_startAdr = MvmvaAdr;
			SQR:     o_startAdr = SqrAdr;
			GPF:     o_startAdr = GpfAdr;
			default: o_startAdr = NopAdr;  // NOP and every unknown code
		endcase
	end

	// ------------------------------------------------------------------------
	// Micro-op ROM
	// ------------------------------------------------------------------------

	always_comb begin
		case (i_pc)
			// Single step, nothing written
			NopAdr:           o_microOp = uop(MATRIX_ROW, 2'd1, 1'b0, 1'b0, 1'b1);

			// MVMVA, row i of R times vector, TR gated later by cv
			MvmvaAdr:         o_microOp = uop(MATRIX_ROW, 2'd1, 1'b1, 1'b1, 1'b0);
			MvmvaAdr + 6'd1:  o_microOp = uop(MATRIX_ROW, 2'd2, 1'b1, 1'b1, 1'b0);
			MvmvaAdr + 6'd2:  o_microOp = uop(MATRIX_ROW, 2'd3, 1'b1, 1'b1, 1'b1);

			// SQR
			SqrAdr:           o_microOp = uop(SQUARE, 2'd1, 1'b0, 1'b1, 1'b0);
			SqrAdr + 6'd1:    o_microOp = uop(SQUARE, 2'd2, 1'b0, 1'b1, 1'b0);
			SqrAdr + 6'd2:    o_microOp = uop(SQUARE, 2'd3, 1'b0, 1'b1, 1'b1);

			// GPF
			GpfAdr:           o_microOp = uop(IR0_SCALE, 2'd1, 1'b0, 1'b1, 1'b0);
			GpfAdr + 6'd1:    o_microOp = uop(IR0_SCALE, 2'd2, 1'b0, 1'b1, 1'b0);
			GpfAdr + 6'd2:    o_microOp = uop(IR0_SCALE, 2'd3, 1'b0, 1'b1, 1'b1);

			// Unused space behaves like NOP so a stray PC still terminates
			default:          o_microOp = uop(MATRIX_ROW, 2'd1, 1'b0, 1'b0, 1'b1);
		endcase
	end

endmodule

`default_nettype wire

//--- src/gteSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module gteSequencer (
	input  wire                          i_clk,
	input  wire                          i_rst,
	input  wire                          i_run,
	input  wire [gtePkg::InstrWidth-1:0] i_instruction,
	input  wire [gtePkg::PcWidth-1:0]    i_startAdr,
	input  wire gtePkg::sMicroOp         i_microOp,
	output logic [gtePkg::PcWidth-1:0]   o_pc,
	output gtePkg::sMicroOp              o_step,
	output gtePkg::sInstrCtrl            o_instrCtrl,
	output logic                         o_load,
	output logic                         o_executing
);
	import gtePkg::*;

	logic [PcWidth-1:0] pcQ;
	logic [PcWidth-1:0] pcNext;
	logic               executingQ;
	logic               load;
	sInstrCtrl          ctrlQ;

	// ------------------------------------------------------------------------
	// Next PC
	// ------------------------------------------------------------------------

	assign load = i_run && !executingQ;  // Strobe ignored while busy

	always_comb begin
		if (load) begin
			pcNext = i_startAdr;     // Straight from start table, no extra cycle
		end else if (!executingQ) begin
			pcNext = '0;             // Park on NOP entry
		end else begin
			pcNext = pcQ + 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// PC, field latch and busy flag
	// ------------------------------------------------------------------------

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			pcQ        <= '0;
			executingQ <= 1'b0;
			ctrlQ      <= '0;
		end else begin
			pcQ <= pcNext;
			if (load) begin
				executingQ <= 1'b1;
				ctrlQ.sf   <= i_instruction[SfBit];
				ctrlQ.lm   <= i_instruction[LmBit];
				ctrlQ.cv   <= i_instruction[CvLsb +: 2];
				ctrlQ.vec  <= i_instruction[VecLsb +: 2];
			end else if (i_microOp.last) begin
				executingQ <= 1'b0;  // Drops at the edge ending the last step
			end
		end
	end

	// Outputs
	assign o_pc        = pcQ;
	assign o_step      = executingQ ? i_microOp : '0;  // Idle steps carry no write
	assign o_instrCtrl = ctrlQ;
	assign o_load      = load;
	assign o_executing = executingQ;

	// Every program in the ROM must reach a step marked last
	execBounded: assert property (
		@(posedge i_clk) disable iff (i_rst)
		$rose(executingQ) |-> ##[1:ExecLimit] !executingQ
	) else $error("Sequencer busy longer than %0d cycles", ExecLimit);

endmodule

`default_nettype wire

//--- src/gtePkg.sv
`default_nettype none

package gtePkg;

	// ------------------------------------------------------------------------
	// Widths and arithmetic constants
	// ------------------------------------------------------------------------

	localparam int PcWidth    = 6;       // Microcode address
	localparam int AccWidth   = 48;      // Three products plus TR term
	localparam int FracBits   = 12;      // Shift when sf is set
	localparam int InstrWidth = 25;      // CPU instruction word
	localparam int IrMax      = 32767;   // Upper IR clamp
	localparam int IrMin      = -32768;  // Lower IR clamp when lm is clear
	localparam int ExecLimit  = 8;       // Longest legal busy time in cycles

	// Instruction word bit positions
	localparam int LmBit  = 10;
	localparam int CvLsb  = 13;  // Two bits
	localparam int VecLsb = 15;  // Two bits
	localparam int SfBit  = 19;

	// Microcode ROM layout, one entry per step
	localparam logic [PcWidth-1:0] NopAdr   = 6'd0;
	localparam logic [PcWidth-1:0] MvmvaAdr = 6'd1;  // Lanes 1..3 at 1..3
	localparam logic [PcWidth-1:0] SqrAdr   = 6'd4;  // Lanes 1..3 at 4..6
	localparam logic [PcWidth-1:0] GpfAdr   = 6'd7;  // Lanes 1..3 at 7..9

	typedef logic signed [15:0] tS16;

	// ------------------------------------------------------------------------
	// Enumerations
	// ------------------------------------------------------------------------

	// CPU visible register ids
	typedef enum logic [4:0] {
		VX0, VY0, VZ0,
		VX1, VY1, VZ1,
		IR0, IR1, IR2, IR3,
		MAC1, MAC2, MAC3,
		FLAG,
		R11, R12, R13,
		R21, R22, R23,
		R31, R32, R33,
		TRX, TRY, TRZ
	} eRegId;

	// Low six bits of the instruction, anything else runs as NOP
	typedef enum logic [5:0] {
		NOP   = 6'h00,
		MVMVA = 6'h12,
		SQR   = 6'h28,
		GPF   = 6'h3D
	} eOpcode;

	// Product source for one micro-step
	typedef enum logic [1:0] {
		MATRIX_ROW,  // Rotation row times vector
		SQUARE,      // IRi times IRi
		IR0_SCALE    // IR0 times IRi
	} eTermSel;

	// ------------------------------------------------------------------------
	// Structs between blocks
	// ------------------------------------------------------------------------

	typedef struct packed {
		eTermSel    termSel;
		logic [1:0] lane;     // 1..3
		logic       addTr;    // Add TR when cv permits
		logic       writeEn;
		logic       last;     // Final step of the program
	} sMicroOp;

	typedef struct packed {
		logic       sf;   // Shift result by FracBits
		logic       lm;   // Clamp low at zero
		logic [1:0] cv;   // 0 TR, 3 none
		logic [1:0] vec;  // 0 V0, 1 V1, else IR1..IR3
	} sInstrCtrl;

	typedef struct packed {
		tS16 [2:0]      v0;  // Index 0 is X
		tS16 [2:0]      v1;
		tS16 [3:0]      ir;  // ir[0] is IR0
		tS16 [2:0][2:0] rt;  // rt[row][col], rt[0][0] is R11
		tS16 [2:0]      tr;
	} sRegView;

	typedef struct packed {
		logic               en;
		logic [1:0]         lane;
		logic signed [31:0] mac;
		tS16                ir;
		logic               sat;   // IR was clamped
	} sWriteBack;

endpackage

`default_nettype wire
